// ==== common/icap_pkg.sv ====
package icap_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	// Log2 of the port clock divide
	localparam int icap_lgdiv = 3;
	localparam int reg_addr_w = 5;
	localparam int word_w = 32;
	localparam int sel_w = word_w / 8;
	localparam int step_w = 5;
	// Register field width inside a type-1 header
	localparam int hdr_reg_w = 14;

	//////////////////////////////
	// Packet constants
	//////////////////////////////

	localparam logic [word_w-1:0] word_dummy = 32'hffff_ffff;
	localparam logic [word_w-1:0] word_noop = 32'h2000_0000;
	localparam logic [word_w-1:0] word_sync = 32'haa99_5566;
	localparam logic [word_w-1:0] word_desync = 32'h0000_000d;
	// CMD register
	localparam logic [reg_addr_w-1:0] reg_cmd = 5'd4;
	localparam logic [2:0] hdr_type1 = 3'd1;
	localparam logic [1:0] op_read = 2'd1;
	localparam logic [1:0] op_write = 2'd2;

	//////////////////////////////
	// Sequencer steps
	//////////////////////////////

	typedef logic [step_w-1:0] step_t;

	// Unnamed steps in between simply count up
	localparam step_t step_idle = 5'h00;
	localparam step_t step_start = 5'h01;
	localparam step_t step_sync_end = 5'h05;
	localparam step_t step_read = 5'h06;
	localparam step_t step_read_end = 5'h0e;
	localparam step_t step_write = 5'h0f;
	localparam step_t step_write_end = 5'h10;
	localparam step_t step_desync = 5'h11;
	localparam step_t step_end = 5'h17;
	// Ticks the desync tail still runs after a read answer
	localparam step_t read_tail = step_t'(step_end - step_desync + 1'b1);

	// Bus request as held by the host
	typedef struct packed {
		logic we;
		logic [reg_addr_w-1:0] addr;
		logic [word_w-1:0] data;
		logic [sel_w-1:0] sel;
	} bus_req_t;

	typedef struct packed {
		logic ack;
		logic [word_w-1:0] data;
	} bus_rsp_t;

	// Port side, data already bit-reversed per byte
	typedef struct packed {
		logic cs_n;
		logic rdwrn;
		logic [word_w-1:0] data;
	} cfg_port_t;

	typedef struct packed {
		logic [2:0] hdr_type;
		logic [1:0] opcode;
		logic [hdr_reg_w-1:0] reg_addr;
		logic [1:0] reserved;
		logic [10:0] word_count;
	} type1_hdr_t;

	// Same port word seen raw or as a header
	typedef union packed {
		logic [word_w-1:0] raw;
		type1_hdr_t hdr;
	} cfg_word_u;

	// Port wants each byte MSB/LSB swapped
	function automatic logic [word_w-1:0] byte_bit_rev(input logic [word_w-1:0] w);
		logic [word_w-1:0] r;
		for (int b = 0; b < sel_w; b++) begin
			for (int k = 0; k < 8; k++) begin
				r[8*b + k] = w[8*b + 7 - k];
			end
		end
		return r;
	endfunction

endpackage

// ==== verilog/icap_clk_div.sv ====
module icap_clk_div (
	input logic i_clk,
	input logic i_rst_n,
	output logic o_tick,
	output logic o_slow_clk
);

	import icap_pkg::*;

	// Free-running divide counter
	logic [icap_lgdiv-1:0] cnt;

	//////////////////////////////
	// Counter and tick
	//////////////////////////////

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			cnt <= '0;
			o_tick <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
			// Registered one count early
			// so tick sits on the last count
			o_tick <= (cnt == {{(icap_lgdiv-1){1'b1}}, 1'b0});
		end
	end

	// Top bit is the port clock
	// Falls on the edge right after the tick
	assign o_slow_clk = cnt[icap_lgdiv-1];

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Tick is a single-cycle strobe per period
	a_tick_single: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_tick |=> !o_tick
	);

endmodule

// ==== verilog/icap_bus_front.sv ====
module icap_bus_front (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_tick,
	input logic i_stb,
	input icap_pkg::bus_req_t i_req,
	input logic i_done,
	input logic [icap_pkg::word_w-1:0] i_rdata,
	output logic o_stall,
	output logic o_start,
	output icap_pkg::bus_req_t o_seq_req,
	output icap_pkg::bus_rsp_t o_rsp
);

	import icap_pkg::*;

	logic busy;
	logic accept;
	logic full_sel;
	// Partial select answer, one cycle after accept
	logic part_ack;
	// Ticks left in the desync tail after a read
	step_t tail;
	bus_req_t req_q;

	//////////////////////////////
	// Handshake
	//////////////////////////////

	// Accept only on a tick while idle
	assign o_stall = busy || !i_tick;
	assign accept = i_stb && !o_stall;
	assign full_sel = &i_req.sel;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			busy <= 1'b0;
			o_start <= 1'b0;
			part_ack <= 1'b0;
			tail <= '0;
		end else begin
			o_start <= accept && full_sel;
			part_ack <= accept && !full_sel;
			if (accept && full_sel) begin
				busy <= 1'b1;
			end else if (i_done) begin
				// Write ends with the sequence
				// Read still has the desync to play
				if (req_q.we) begin
					busy <= 1'b0;
				end else begin
					tail <= read_tail;
				end
			end else if (i_tick && tail != '0) begin
				tail <= tail - 1'b1;
				// Sequencer back to idle on this tick
				if (tail == step_t'(1)) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// Held request for the sequencer
	always_ff @(posedge i_clk) begin
		if (accept) begin
			req_q <= i_req;
		end
	end

	assign o_seq_req = req_q;

	//////////////////////////////
	// Response
	//////////////////////////////

	// Ack in the same cycle as done
	always_comb begin
		o_rsp.ack = i_done || part_ack;
		o_rsp.data = i_rdata;
	end

	// Answer never overlaps a new accept
	a_no_ack_on_accept: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_rsp.ack |-> !accept
	);

endmodule

// ==== icap_seq/icap_seq.sv ====
module icap_seq (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_tick,
	input logic i_start,
	input icap_pkg::bus_req_t i_req,
	input logic [icap_pkg::word_w-1:0] i_cfg_rdata,
	output logic o_done,
	output logic [icap_pkg::word_w-1:0] o_rdata,
	output icap_pkg::cfg_port_t o_cfg
);

	import icap_pkg::*;

	step_t step;
	step_t step_nxt;
	logic cs_n_nxt;
	logic rdwrn_nxt;
	logic [word_w-1:0] word_nxt;
	// Done strobe for this step
	logic fin;
	// Port answer valid at this step
	logic capture;

	// Type-1 header with a single word count
	function automatic logic [word_w-1:0] type1_word(input logic [1:0] op,
			input logic [reg_addr_w-1:0] addr);
		cfg_word_u w;
		w.raw = '0;
		w.hdr.hdr_type = hdr_type1;
		w.hdr.opcode = op;
		w.hdr.reg_addr = hdr_reg_w'(addr);
		w.hdr.word_count = 11'd1;
		return w.raw;
	endfunction

	//////////////////////////////
	// Step decode
	//////////////////////////////

	always_comb begin
		step_nxt = step + 1'b1;
		cs_n_nxt = 1'b0;
		rdwrn_nxt = o_cfg.rdwrn;
		word_nxt = word_noop;
		fin = 1'b0;
		capture = 1'b0;
		case (step)
			step_idle: begin
				// Port parked
				step_nxt = step_idle;
				cs_n_nxt = 1'b1;
				rdwrn_nxt = 1'b1;
				word_nxt = word_dummy;
			end
			step_start: begin
				cs_n_nxt = 1'b1;
				word_nxt = word_dummy;
			end
			5'h02: begin
				// Select port for writing
				rdwrn_nxt = 1'b0;
			end
			5'h03: begin
				word_nxt = word_sync;
			end
			5'h04: begin
			end
			step_sync_end: begin
				// Branch on direction
				step_nxt = i_req.we ? step_write : step_read;
			end
			step_read: begin
				word_nxt = type1_word(op_read, i_req.addr);
			end
			5'h07, 5'h08: begin
			end
			5'h09: begin
				// Deselect before turning the bus around
				cs_n_nxt = 1'b1;
				rdwrn_nxt = 1'b1;
			end
			5'h0a, 5'h0b, 5'h0c, 5'h0d: begin
				// Four read wait words
				rdwrn_nxt = 1'b1;
			end
			step_read_end: begin
				// Answer is on the port now
				cs_n_nxt = 1'b1;
				rdwrn_nxt = 1'b1;
				step_nxt = step_desync;
				fin = !i_req.we;
				capture = 1'b1;
			end
			step_write: begin
				word_nxt = type1_word(op_write, i_req.addr);
			end
			step_write_end: begin
				word_nxt = i_req.data;
			end
			step_desync: begin
				rdwrn_nxt = 1'b0;
			end
			5'h12: begin
			end
			5'h13: begin
				// Write to CMD
				word_nxt = type1_word(op_write, reg_cmd);
			end
			5'h14: begin
				word_nxt = word_desync;
			end
			5'h15, 5'h16: begin
			end
			step_end: begin
				cs_n_nxt = 1'b1;
				rdwrn_nxt = 1'b0;
				word_nxt = word_dummy;
				step_nxt = step_idle;
				fin = i_req.we;
			end
			default: begin
				cs_n_nxt = 1'b1;
				rdwrn_nxt = 1'b0;
				word_nxt = word_dummy;
				step_nxt = step_idle;
			end
		endcase
	end

	//////////////////////////////
	// Port registers
	//////////////////////////////

	// Port fields move only after a tick
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			step <= step_idle;
			o_cfg.cs_n <= 1'b1;
			o_cfg.rdwrn <= 1'b1;
			o_cfg.data <= byte_bit_rev(word_dummy);
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start && step == step_idle) begin
				// Port untouched until the next tick
				step <= step_start;
			end else if (i_tick) begin
				step <= step_nxt;
				o_cfg.cs_n <= cs_n_nxt;
				o_cfg.rdwrn <= rdwrn_nxt;
				o_cfg.data <= byte_bit_rev(word_nxt);
				o_done <= fin;
			end
		end
	end

	// Read answer, back to normal bit order
	always_ff @(posedge i_clk) begin
		if (i_tick && capture) begin
			o_rdata <= byte_bit_rev(i_cfg_rdata);
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Port deselected whenever parked
	a_idle_cs: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		step == step_idle |-> o_cfg.cs_n
	);

	a_step_range: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		step <= step_end
	);

endmodule

// ==== verilog/icap_bridge_top.sv ====
module icap_bridge_top (
	input logic i_clk,
	input logic i_rst_n,
	// Host bus
	input logic i_stb,
	input icap_pkg::bus_req_t i_req,
	output logic o_stall,
	output icap_pkg::bus_rsp_t o_rsp,
	// Configuration port
	output logic o_cfg_clk,
	output icap_pkg::cfg_port_t o_cfg,
	input logic [icap_pkg::word_w-1:0] i_cfg_rdata
);

	import icap_pkg::*;

	logic tick;
	logic start;
	logic done;
	bus_req_t seq_req;
	logic [word_w-1:0] rdata;

	//////////////////////////////
	// Divider
	//////////////////////////////

	icap_clk_div u_clk_div (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.o_tick(tick),
		.o_slow_clk(o_cfg_clk)
	);

	//////////////////////////////
	// Bus front end
	//////////////////////////////

	icap_bus_front u_bus_front (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_tick(tick),
		.i_stb(i_stb),
		.i_req(i_req),
		.i_done(done),
		.i_rdata(rdata),
		.o_stall(o_stall),
		.o_start(start),
		.o_seq_req(seq_req),
		.o_rsp(o_rsp)
	);

	// Packet sequencer
	icap_seq u_seq (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_tick(tick),
		.i_start(start),
		.i_req(seq_req),
		.i_cfg_rdata(i_cfg_rdata),
		.o_done(done),
		.o_rdata(rdata),
		.o_cfg(o_cfg)
	);

endmodule

// ==== tests/tb_cfg_port_model.sv ====
module tb_cfg_port_model (
	input logic i_cfg_clk,
	input icap_pkg::cfg_port_t i_cfg,
	// Request the next frame should carry
	input logic i_exp_we,
	input logic [icap_pkg::reg_addr_w-1:0] i_exp_addr,
	input logic [icap_pkg::word_w-1:0] i_exp_data,
	output logic [icap_pkg::word_w-1:0] o_rdata,
	output int o_frames,
	output int o_words,
	output logic o_err
);

	import icap_pkg::*;

	logic [word_w-1:0] regs [32];
	logic armed;
	logic wr_pend;
	logic [reg_addr_w-1:0] wr_addr;
	logic prev_cs_n;
	// Frame position and read-shape counters
	int idx;
	int waits;
	int rises;
	// Request latched at the first frame word
	logic fr_we;
	logic [reg_addr_w-1:0] fr_addr;
	logic [word_w-1:0] fr_data;
	cfg_word_u w;
	logic [word_w-1:0] exp_w;

	// Expected write-phase word at frame position idx
	function automatic logic [word_w-1:0] frame_word(input int pos, input logic we,
			input logic [reg_addr_w-1:0] addr, input logic [word_w-1:0] data);
		cfg_word_u h;
		cfg_word_u c;
		int k;
		h.raw = '0;
		h.hdr.hdr_type = hdr_type1;
		h.hdr.opcode = we ? op_write : op_read;
		h.hdr.reg_addr = hdr_reg_w'(addr);
		h.hdr.word_count = 11'd1;
		c = h;
		c.hdr.opcode = op_write;
		c.hdr.reg_addr = hdr_reg_w'(reg_cmd);
		if (pos == 1) return word_sync;
		if (pos == 4) return h.raw;
		if (we && pos == 5) return data;
		// Read frame runs one word longer before the tail
		k = we ? pos : pos - 1;
		if (k == 8) return c.raw;
		if (k == 9) return word_desync;
		return word_noop;
	endfunction

	initial begin
		for (int a = 0; a < 32; a++) begin
			regs[a] = '0;
		end
		o_rdata = '0;
		o_frames = 0;
		o_words = 0;
		o_err = 1'b0;
		armed = 1'b0;
		wr_pend = 1'b0;
		prev_cs_n = 1'b1;
		idx = 0;
		waits = 0;
		rises = 0;
	end

	//////////////////////////////
	// Port sampling
	//////////////////////////////

	always @(posedge i_cfg_clk) begin
		if (!i_cfg.cs_n) begin
			o_words++;
		end
		// Deselect before the wait words
		if (armed && !prev_cs_n && i_cfg.cs_n && waits < 4) begin
			rises++;
		end
		if (!i_cfg.cs_n && i_cfg.rdwrn) begin
			waits++;
		end
		if (!i_cfg.cs_n && !i_cfg.rdwrn) begin
			w.raw = byte_bit_rev(i_cfg.data);
			if (idx == 0) begin
				fr_we = i_exp_we;
				fr_addr = i_exp_addr;
				fr_data = i_exp_data;
			end
			exp_w = frame_word(idx, fr_we, fr_addr, fr_data);
			if (w.raw !== exp_w) begin
				$display("error: t=%0t cfg word %0d got %h expected %h", $time, idx, w.raw,
					exp_w);
				o_err = 1'b1;
			end
			// Decode as a device would
			if (armed && wr_pend) begin
				regs[wr_addr] = w.raw;
				wr_pend = 1'b0;
				if (wr_addr == reg_cmd && w.raw == word_desync) begin
					armed = 1'b0;
				end
			end else if (w.raw == word_sync) begin
				armed = 1'b1;
			end else if (armed && w.hdr.hdr_type == hdr_type1) begin
				if (w.hdr.opcode == op_write) begin
					wr_pend = 1'b1;
					wr_addr = w.hdr.reg_addr[reg_addr_w-1:0];
				end else if (w.hdr.opcode == op_read) begin
					o_rdata = byte_bit_rev(regs[w.hdr.reg_addr[reg_addr_w-1:0]]);
				end
			end
			// Last NOOP closes the frame
			if (idx == (fr_we ? 11 : 12)) begin
				if (waits != (fr_we ? 0 : 4) || rises != (fr_we ? 0 : 1)) begin
					$display("error: t=%0t read waits/cs_n rises got %0d/%0d expected %0d/%0d",
						$time, waits, rises, fr_we ? 0 : 4, fr_we ? 0 : 1);
					o_err = 1'b1;
				end
				o_frames++;
				idx = 0;
				waits = 0;
				rises = 0;
			end else begin
				idx++;
			end
		end
		prev_cs_n = i_cfg.cs_n;
	end

endmodule

// ==== tests/tb_icap_bridge.sv ====
module tb_icap_bridge;

	import icap_pkg::*;

	logic clk;
	logic rst_n;
	logic stb;
	bus_req_t req;
	logic stall;
	bus_rsp_t rsp;
	logic cfg_clk;
	cfg_port_t cfg;
	logic [word_w-1:0] cfg_rdata;
	logic exp_we;
	logic [reg_addr_w-1:0] exp_addr;
	logic [word_w-1:0] exp_data;
	int frames;
	int words;
	logic model_err;
	logic [31:0] lfsr_state;
	// Register file as the host expects it
	logic [word_w-1:0] shadow [32];
	int acks = 0;
	int reqs = 0;
	int frames_exp = 0;

	icap_bridge_top icap_bridge_top_inst (
		.i_clk(clk),
		.i_rst_n(rst_n),
		.i_stb(stb),
		.i_req(req),
		.o_stall(stall),
		.o_rsp(rsp),
		.o_cfg_clk(cfg_clk),
		.o_cfg(cfg),
		.i_cfg_rdata(cfg_rdata)
	);

	tb_cfg_port_model port_model_inst (
		.i_cfg_clk(cfg_clk),
		.i_cfg(cfg),
		.i_exp_we(exp_we),
		.i_exp_addr(exp_addr),
		.i_exp_data(exp_data),
		.o_rdata(cfg_rdata),
		.o_frames(frames),
		.o_words(words),
		.o_err(model_err)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Ack counted mid-cycle, away from the edges
	always @(negedge clk) begin
		if (rst_n && rsp.ack) acks++;
	end

	always @(posedge model_err) stop_with_failure("port model saw a bad frame");

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic stop_with_failure(input string why);
		$display("Checks failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
		if (got !== exp) begin
			$display("error: t=%0t %s got %h expected %h", $time, name, got, exp);
			stop_with_failure("bus response mismatch");
		end
	endtask

	task automatic check_port(input string name, input cfg_port_t got, input cfg_port_t exp);
		if (got !== exp) begin
			$display("error: t=%0t %s got %h expected %h", $time, name, got, exp);
			stop_with_failure("port word mismatch");
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("error: t=%0t %s got %0d expected %0d", $time, name, got, exp);
			stop_with_failure("count mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error: t=%0t %s got %b expected %b", $time, name, got, exp);
			stop_with_failure("handshake flag mismatch");
		end
	endtask

	task automatic check_word(input string name, input logic [word_w-1:0] got,
			input logic [word_w-1:0] exp);
		if (got !== exp) begin
			$display("error: t=%0t %s got %h expected %h", $time, name, got, exp);
			stop_with_failure("register word mismatch");
		end
	endtask

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	// Hold the request through stall, then wait for its ack
	task automatic bus_access(input bus_req_t r, output bus_rsp_t got);
		int n;
		check_count("ack count", acks, reqs);
		stb = 1'b1;
		req = r;
		exp_we = r.we;
		exp_addr = r.addr;
		exp_data = r.data;
		n = 0;
		while (stall) begin
			next_cycle();
			n++;
			if (n > 400) stop_with_failure("request held through stall was never accepted");
		end
		next_cycle();
		stb = 1'b0;
		reqs++;
		n = 0;
		while (!rsp.ack) begin
			// Busy with this request until it is answered
			check_flag("o_stall", stall, 1'b1);
			next_cycle();
			n++;
			if (n > 400) stop_with_failure("no ack for an accepted request");
		end
		got = rsp;
		// Let the ack counter see this cycle
		next_cycle();
	endtask

	task automatic wait_frames(input int target);
		int n;
		n = 0;
		while (frames < target) begin
			// Desync tail still running
			check_flag("o_stall", stall, 1'b1);
			next_cycle();
			n++;
			if (n > 400) stop_with_failure("configuration frame never finished");
		end
		check_count("frame count", frames, target);
	endtask

	// Issue one request and check it against the shadow copy
	task automatic run_op(input bus_req_t r);
		bus_rsp_t got;
		bus_rsp_t exp;
		int words_before;
		words_before = words;
		bus_access(r, got);
		if (&r.sel) begin
			if (r.we) begin
				shadow[r.addr] = r.data;
			end else begin
				exp.ack = 1'b1;
				exp.data = shadow[r.addr];
				check_rsp("o_rsp", got, exp);
			end
			// Every frame ends writing DESYNC to CMD
			shadow[reg_cmd] = word_desync;
			frames_exp++;
			wait_frames(frames_exp);
		end else begin
			// Four port periods, long enough for a stray first word
			repeat (32) next_cycle();
			check_count("frame count", frames, frames_exp);
			check_count("port words", words, words_before);
		end
	endtask

	task automatic check_regs();
		for (int a = 0; a < 32; a++) begin
			check_word($sformatf("model reg %0d", a), port_model_inst.regs[a], shadow[a]);
		end
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		bus_req_t r;
		cfg_port_t park;
		logic [31:0] v;
		lfsr_state = 32'd83509;
		rst_n = 1'b0;
		stb = 1'b0;
		req = '0;
		exp_we = 1'b0;
		exp_addr = '0;
		exp_data = '0;
		for (int a = 0; a < 32; a++) begin
			shadow[a] = '0;
		end
		repeat (8) @(posedge clk);
		#10;
		rst_n = 1'b1;

		// Parked port, dummy word is all ones either bit order
		park.cs_n = 1'b1;
		park.rdwrn = 1'b1;
		park.data = word_dummy;
		check_count("o_rsp.ack", int'(rsp.ack), 0);
		check_port("o_cfg", cfg, park);
		repeat (20) next_cycle();
		check_count("o_rsp.ack", int'(rsp.ack), 0);
		check_count("port words", words, 0);

		// Directed write, reads, partial select
		r = '{we: 1'b1, addr: 5'd3, data: 32'h1234_5678, sel: 4'hf};
		run_op(r);
		r = '{we: 1'b0, addr: 5'd3, data: '0, sel: 4'hf};
		run_op(r);
		r = '{we: 1'b0, addr: 5'd9, data: '0, sel: 4'hf};
		run_op(r);
		r = '{we: 1'b1, addr: 5'd3, data: 32'hdead_beef, sel: 4'h3};
		run_op(r);
		check_regs();

		// Random mix, roughly one in eight partial
		for (int i = 0; i < 200; i++) begin
			take_bits(1, v);
			r.we = v[0];
			take_bits(reg_addr_w, v);
			r.addr = v[reg_addr_w-1:0];
			take_bits(word_w, v);
			r.data = v;
			take_bits(3, v);
			r.sel = 4'hf;
			if (v[2:0] == 3'd0) begin
				take_bits(4, v);
				r.sel = (v[3:0] == 4'hf) ? 4'h7 : v[3:0];
			end
			run_op(r);
		end
		check_regs();
		check_count("ack count", acks, reqs);

		if (model_err) begin
			stop_with_failure("port model flagged an error at the end of the run");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// ==== tb.f ====
common/icap_pkg.sv
verilog/icap_clk_div.sv
verilog/icap_bus_front.sv
icap_seq/icap_seq.sv
verilog/icap_bridge_top.sv
tests/tb_cfg_port_model.sv
tests/tb_icap_bridge.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the bridge testbench with Verilator and run it
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_icap_bridge -f tb.f -o tb_icap_bridge \
	&& ./obj_dir/tb_icap_bridge \
	|| { echo "simulation failed"; exit 1; }
